// ==== src/agc_params.svh ====
`ifndef AGC_PARAMS_SVH
`define AGC_PARAMS_SVH

// frame geometry
`define AGC_LANES           8
`define AGC_ADC_W           12
`define AGC_OUT_W           5

// gain arithmetic with 4096 as unity scale
`define AGC_SCALE_W         13
`define AGC_SCALE_FRAC      12
`define AGC_OFFSET_W        14
`define AGC_SCALE_RESET     13'd4096

// measurement over 2**5 frames per period
`define AGC_PERIOD_LOG2     5
`define AGC_SQ_W            25
`define AGC_CNT_W           16

// wishbone
`define AGC_ADR_W           8
`define AGC_DAT_W           32

// register map
`define AGC_REG_CTRL        8'h00
`define AGC_REG_SQ          8'h04
`define AGC_REG_GT          8'h08
`define AGC_REG_LT          8'h0C
`define AGC_REG_SCALE       8'h10
`define AGC_REG_OFFSET      8'h14

// ctrl register bit positions
`define AGC_CTRL_START      0
`define AGC_CTRL_CLEAR      2
`define AGC_CTRL_LOAD_SCALE 8
`define AGC_CTRL_LOAD_OFFSET 9
`define AGC_CTRL_APPLY      10

`endif

// ==== src/agc_pkg.sv ====
`include "agc_params.svh"

package agc_pkg;

    // raw adc sample in two's complement
    typedef logic signed [`AGC_ADC_W-1:0] adc_sample_t;

    // trigger sample after saturation
    typedef logic signed [`AGC_OUT_W-1:0] trig_sample_t;

    // unsigned scale as a fraction of 4096
    typedef logic [`AGC_SCALE_W-1:0] agc_scale_t;
    typedef logic signed [`AGC_OFFSET_W-1:0] agc_offset_t;

    // offset-corrected sample times scale
    typedef logic signed [`AGC_OFFSET_W+`AGC_SCALE_W-1:0] gain_prod_t;

    // measurement results
    typedef logic [`AGC_SQ_W-1:0] sq_acc_t;
    typedef logic [`AGC_CNT_W-1:0] agc_cnt_t;

    // one frame per wbclk with lane 0 in the low bits
    typedef adc_sample_t [`AGC_LANES-1:0] adc_frame_t;
    typedef gain_prod_t [`AGC_LANES-1:0] prod_frame_t;
    typedef trig_sample_t [`AGC_LANES-1:0] trig_frame_t;

    // active gain as seen by the datapath
    typedef struct packed {
        agc_scale_t  scale;
        agc_offset_t offset;
    } agc_gain_t;

    // single-cycle measurement commands
    typedef struct packed {
        logic start;
        logic clear;
    } agc_cmd_t;

    // results back to the register block
    typedef struct packed {
        sq_acc_t  sq;
        agc_cnt_t gt;
        agc_cnt_t lt;
        logic     done;
    } agc_stats_t;

endpackage

// ==== src/agc_wb_regs.sv ====
`timescale 1ns/1ps
`include "agc_params.svh"

module agc_wb_regs (
    input  logic                  wbclk,
    input  logic                  reset_i,
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  logic [`AGC_ADR_W-1:0] wb_adr_i,
    input  logic [`AGC_DAT_W-1:0] wb_dat_i,
    output logic [`AGC_DAT_W-1:0] wb_dat_o,
    output logic                  wb_ack_o,
    input  agc_pkg::agc_stats_t   stats_i,
    output agc_pkg::agc_gain_t    gain_o,
    output agc_pkg::agc_cmd_t     cmd_o
);

    // new bus request while ack is low
    logic req;
    logic wr_req;
    logic wr_ctrl;
    logic wr_scale;
    logic wr_offset;

    // bus-side copy and load-side copy of the gain
    agc_pkg::agc_gain_t shadow;
    agc_pkg::agc_gain_t staging;

    logic [`AGC_DAT_W-1:0] rd_data;

    assign req    = wb_cyc_i & wb_stb_i & ~wb_ack_o;
    assign wr_req = req & wb_we_i;

    // address decode for writes
    assign wr_ctrl   = wr_req & (wb_adr_i == `AGC_REG_CTRL);
    assign wr_scale  = wr_req & (wb_adr_i == `AGC_REG_SCALE);
    assign wr_offset = wr_req & (wb_adr_i == `AGC_REG_OFFSET);

    // ack one cycle after the request and never twice in a row
    always_ff @(posedge wbclk) begin
        if (reset_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= req;
        end
    end

    // shadow level written straight from the bus
    always_ff @(posedge wbclk) begin
        if (reset_i) begin
            shadow.scale  <= `AGC_SCALE_RESET;
            shadow.offset <= '0;
        end else begin
            if (wr_scale) begin
                shadow.scale <= wb_dat_i[`AGC_SCALE_W-1:0];
            end
            if (wr_offset) begin
                shadow.offset <= wb_dat_i[`AGC_OFFSET_W-1:0];
            end
        end
    end

    // staging level with per-field load bits
    always_ff @(posedge wbclk) begin
        if (reset_i) begin
            staging.scale  <= `AGC_SCALE_RESET;
            staging.offset <= '0;
        end else if (wr_ctrl) begin
            if (wb_dat_i[`AGC_CTRL_LOAD_SCALE]) begin
                staging.scale <= shadow.scale;
            end
            if (wb_dat_i[`AGC_CTRL_LOAD_OFFSET]) begin
                staging.offset <= shadow.offset;
            end
        end
    end

    // active level
    // load+apply in one write moves the old staging value
    always_ff @(posedge wbclk) begin
        if (reset_i) begin
            gain_o.scale  <= `AGC_SCALE_RESET;
            gain_o.offset <= '0;
        end else if (wr_ctrl && wb_dat_i[`AGC_CTRL_APPLY]) begin
            gain_o <= staging;
        end
    end

    // measurement commands high for the ack cycle only
    always_ff @(posedge wbclk) begin
        if (reset_i) begin
            cmd_o <= '0;
        end else begin
            cmd_o.start <= wr_ctrl & wb_dat_i[`AGC_CTRL_START];
            cmd_o.clear <= wr_ctrl & wb_dat_i[`AGC_CTRL_CLEAR];
        end
    end

    // readback mux
    always_comb begin
        rd_data = '0;
        case (wb_adr_i)
            `AGC_REG_CTRL: begin
                rd_data[0] = stats_i.done;
            end
            `AGC_REG_SQ: begin
                rd_data = {{(`AGC_DAT_W-`AGC_SQ_W){1'b0}}, stats_i.sq};
            end
            `AGC_REG_GT: begin
                rd_data = {{(`AGC_DAT_W-`AGC_CNT_W){1'b0}}, stats_i.gt};
            end
            `AGC_REG_LT: begin
                rd_data = {{(`AGC_DAT_W-`AGC_CNT_W){1'b0}}, stats_i.lt};
            end
            `AGC_REG_SCALE: begin
                rd_data = {{(`AGC_DAT_W-`AGC_SCALE_W){1'b0}}, shadow.scale};
            end
            `AGC_REG_OFFSET: begin
                // sign extended so software sees a plain int
                rd_data = {{(`AGC_DAT_W-`AGC_OFFSET_W){shadow.offset[`AGC_OFFSET_W-1]}},
                           shadow.offset};
            end
            default: begin
                rd_data = '0;
            end
        endcase
    end

    // captured with the request and valid while ack is high
    always_ff @(posedge wbclk) begin
        if (req) begin
            wb_dat_o <= rd_data;
        end
    end

    ap_ack_single: assert property (@(posedge wbclk) disable iff (reset_i)
        wb_ack_o |=> !wb_ack_o);

endmodule

// ==== src/agc_gain_stage.sv ====
`timescale 1ns/1ps
`include "agc_params.svh"

module agc_gain_stage (
    input  logic                 wbclk,
    input  logic                 reset_i,
    input  agc_pkg::adc_frame_t  adc_i,
    input  agc_pkg::agc_gain_t   gain_i,
    output agc_pkg::prod_frame_t prod_o
);

    // next product frame
    agc_pkg::prod_frame_t prod_next;

    for (genvar k = 0; k < `AGC_LANES; k++) begin : g_lane
        agc_pkg::adc_sample_t sample;
        agc_pkg::agc_offset_t sum;
        agc_pkg::gain_prod_t  sum_ext;
        agc_pkg::gain_prod_t  scale_ext;

        assign sample = adc_i[k];

        // sum kept at offset width
        // wraps only for offsets near full scale
        assign sum = agc_pkg::agc_offset_t'(sample) + gain_i.offset;

        // sum sign extended while scale is zero extended
        assign sum_ext   = agc_pkg::gain_prod_t'(sum);
        assign scale_ext = agc_pkg::gain_prod_t'(gain_i.scale);

        // 14b x 13b fits in 27 signed bits
        assign prod_next[k] = sum_ext * scale_ext;
    end

    // stage 1 register
    always_ff @(posedge wbclk) begin
        if (reset_i) begin
            prod_o <= '0;
        end else begin
            prod_o <= prod_next;
        end
    end

endmodule

// ==== src/agc_quantize_stage.sv ====
`timescale 1ns/1ps
`include "agc_params.svh"

module agc_quantize_stage (
    input  logic                 wbclk,
    input  logic                 reset_i,
    input  agc_pkg::prod_frame_t prod_i,
    output agc_pkg::trig_frame_t trig_o
);

    localparam int PROD_W  = $bits(agc_pkg::gain_prod_t);
    // width left after dropping the fraction
    localparam int SHIFT_W = PROD_W - `AGC_SCALE_FRAC;

    logic signed [SHIFT_W-1:0] shifted [`AGC_LANES];
    logic [`AGC_LANES-1:0] in_range;
    agc_pkg::trig_frame_t trig_next;

    // reference clamp in integer form
    function automatic int clamp_ref(agc_pkg::gain_prod_t p);
        int v;
        int lo;
        int hi;
        v  = int'(p >>> `AGC_SCALE_FRAC);
        lo = -(1 << (`AGC_OUT_W - 1));
        hi = (1 << (`AGC_OUT_W - 1)) - 1;
        if (v > hi) begin
            return hi;
        end
        if (v < lo) begin
            return lo;
        end
        return v;
    endfunction

    for (genvar k = 0; k < `AGC_LANES; k++) begin : g_lane
        // top product bits act as >>> 12 and floor toward -inf
        assign shifted[k] = prod_i[k][PROD_W-1:`AGC_SCALE_FRAC];

        // fits when all bits above the output msb match it
        assign in_range[k] = (&shifted[k][SHIFT_W-1:`AGC_OUT_W-1]) |
                             ~(|shifted[k][SHIFT_W-1:`AGC_OUT_W-1]);

        // out of range gives -16 for negatives and +15 otherwise
        assign trig_next[k] = in_range[k] ? shifted[k][`AGC_OUT_W-1:0] :
            {shifted[k][SHIFT_W-1], {(`AGC_OUT_W-1){~shifted[k][SHIFT_W-1]}}};

        ap_clamp: assert property (@(posedge wbclk) disable iff (reset_i)
            !$past(reset_i) |->
                int'(agc_pkg::trig_sample_t'(trig_o[k])) == clamp_ref($past(prod_i[k])));
    end

    // stage 2 register
    always_ff @(posedge wbclk) begin
        if (reset_i) begin
            trig_o <= '0;
        end else begin
            trig_o <= trig_next;
        end
    end

endmodule

// ==== src/agc_measure.sv ====
`timescale 1ns/1ps
`include "agc_params.svh"

module agc_measure (
    input  logic                 wbclk,
    input  logic                 reset_i,
    input  agc_pkg::trig_frame_t trig_i,
    input  agc_pkg::agc_cmd_t    cmd_i,
    output agc_pkg::agc_stats_t  stats_o
);

    // square of a 5-bit sample fits in 10 bits
    localparam int LANE_SQ_W = 2 * `AGC_OUT_W;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } meas_state_t;

    meas_state_t state;
    logic [`AGC_PERIOD_LOG2-1:0] period_cnt;
    logic done_q;

    agc_pkg::sq_acc_t  sq_acc;
    agc_pkg::agc_cnt_t gt_acc;
    agc_pkg::agc_cnt_t lt_acc;

    // per-frame contributions
    logic signed [LANE_SQ_W-1:0] lane_sq [`AGC_LANES];
    logic [`AGC_LANES-1:0] lane_pos;
    logic [`AGC_LANES-1:0] lane_neg;
    agc_pkg::sq_acc_t  frame_sq;
    agc_pkg::agc_cnt_t frame_gt;
    agc_pkg::agc_cnt_t frame_lt;

    for (genvar k = 0; k < `AGC_LANES; k++) begin : g_lane
        agc_pkg::trig_sample_t lane;
        logic signed [LANE_SQ_W-1:0] lane_ext;

        assign lane     = trig_i[k];
        assign lane_ext = LANE_SQ_W'(lane);
        assign lane_sq[k] = lane_ext * lane_ext;

        // zero counts as neither
        assign lane_pos[k] = ~lane[`AGC_OUT_W-1] & (|lane);
        assign lane_neg[k] = lane[`AGC_OUT_W-1];
    end

    // add up the eight lanes
    always_comb begin
        frame_sq = '0;
        frame_gt = '0;
        frame_lt = '0;
        for (int k = 0; k < `AGC_LANES; k++) begin
            frame_sq = frame_sq + agc_pkg::sq_acc_t'($unsigned(lane_sq[k]));
            frame_gt = frame_gt + agc_pkg::agc_cnt_t'(lane_pos[k]);
            frame_lt = frame_lt + agc_pkg::agc_cnt_t'(lane_neg[k]);
        end
    end

    always_ff @(posedge wbclk) begin
        if (reset_i) begin
            state      <= IDLE;
            period_cnt <= '0;
            done_q     <= 1'b0;
            sq_acc     <= '0;
            gt_acc     <= '0;
            lt_acc     <= '0;
        end else if (cmd_i.clear || cmd_i.start) begin
            // clear wins and aborts a running period
            state      <= cmd_i.clear ? IDLE : RUN;
            period_cnt <= '0;
            done_q     <= 1'b0;
            sq_acc     <= '0;
            gt_acc     <= '0;
            lt_acc     <= '0;
        end else if (state == RUN) begin
            sq_acc     <= sq_acc + frame_sq;
            gt_acc     <= gt_acc + frame_gt;
            lt_acc     <= lt_acc + frame_lt;
            period_cnt <= period_cnt + 1'b1;
            // last frame of the period
            if (&period_cnt) begin
                state  <= DONE;
                done_q <= 1'b1;
            end
        end
    end

    assign stats_o.sq   = sq_acc;
    assign stats_o.gt   = gt_acc;
    assign stats_o.lt   = lt_acc;
    assign stats_o.done = done_q;

    ap_done_not_run: assert property (@(posedge wbclk) disable iff (reset_i)
        !(done_q && state == RUN));

endmodule

// ==== src/agc_chain_top.sv ====
`timescale 1ns/1ps
`include "agc_params.svh"

module agc_chain_top (
    input  logic                  wbclk,
    input  logic                  reset_i,
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  logic [`AGC_ADR_W-1:0] wb_adr_i,
    input  logic [`AGC_DAT_W-1:0] wb_dat_i,
    output logic [`AGC_DAT_W-1:0] wb_dat_o,
    output logic                  wb_ack_o,
    input  agc_pkg::adc_frame_t   adc_i,
    output agc_pkg::trig_frame_t  trig_o
);

    // register block to datapath
    agc_pkg::agc_gain_t   gain;
    agc_pkg::agc_cmd_t    cmd;
    agc_pkg::agc_stats_t  stats;

    // between the two pipeline stages
    agc_pkg::prod_frame_t prod;

    agc_wb_regs agc_wb_regs_inst (
        .wbclk    (wbclk),
        .reset_i  (reset_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .stats_i  (stats),
        .gain_o   (gain),
        .cmd_o    (cmd)
    );

    // stage 1 adds offset and applies scale
    agc_gain_stage agc_gain_stage_inst (
        .wbclk   (wbclk),
        .reset_i (reset_i),
        .adc_i   (adc_i),
        .gain_i  (gain),
        .prod_o  (prod)
    );

    // stage 2 shifts and saturates
    agc_quantize_stage agc_quantize_stage_inst (
        .wbclk   (wbclk),
        .reset_i (reset_i),
        .prod_i  (prod),
        .trig_o  (trig_o)
    );

    // measures the same frames that leave on trig_o
    agc_measure agc_measure_inst (
        .wbclk   (wbclk),
        .reset_i (reset_i),
        .trig_i  (trig_o),
        .cmd_i   (cmd),
        .stats_o (stats)
    );

endmodule

// ==== testbench/agc_chain_tb.sv ====
`timescale 1ns/1ps
`include "agc_params.svh"

module agc_chain_tb;

    // well above the few hundred cycles all tests take
    localparam int MAX_CYCLES = 3000;

    logic                  wbclk;
    logic                  reset_i;
    logic                  wb_cyc_i;
    logic                  wb_stb_i;
    logic                  wb_we_i;
    logic [`AGC_ADR_W-1:0] wb_adr_i;
    logic [`AGC_DAT_W-1:0] wb_dat_i;
    logic [`AGC_DAT_W-1:0] wb_dat_o;
    logic                  wb_ack_o;
    agc_pkg::adc_frame_t   adc_i;
    agc_pkg::trig_frame_t  trig_o;

    logic [31:0]        lcg_state;
    int                 cycle_cnt;
    // gain the model believes is active
    agc_pkg::agc_gain_t cur_gain;

    agc_chain_top agc_chain_top_inst (
        .wbclk    (wbclk),
        .reset_i  (reset_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .adc_i    (adc_i),
        .trig_o   (trig_o)
    );

    initial begin
        wbclk = 1'b0;
        forever #50 wbclk = ~wbclk;
    end

    // watchdog on total run length
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge wbclk);
            cycle_cnt++;
        end
        abort_run("timeout, tests did not finish within the cycle limit");
    end

    task automatic abort_run(string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic compare_trig(agc_pkg::trig_frame_t got, agc_pkg::trig_frame_t exp,
                                string name);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            abort_run("trigger frame mismatch");
        end
    endtask

    task automatic compare_sq(agc_pkg::sq_acc_t got, agc_pkg::sq_acc_t exp, string name);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
            abort_run("sum of squares mismatch");
        end
    endtask

    task automatic compare_cnt(agc_pkg::agc_cnt_t got, agc_pkg::agc_cnt_t exp, string name);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
            abort_run("counter mismatch");
        end
    endtask

    task automatic compare_word(logic [`AGC_DAT_W-1:0] got, logic [`AGC_DAT_W-1:0] exp,
                                string name);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            abort_run("bus read data mismatch");
        end
    endtask

    // one bus cycle that returns on the falling edge seeing ack
    task automatic bus_access(input logic we, input logic [`AGC_ADR_W-1:0] adr,
                              input logic [`AGC_DAT_W-1:0] wdata,
                              output logic [`AGC_DAT_W-1:0] rdata);
        int waited;
        waited = 0;
        @(negedge wbclk);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdata;
        do begin
            @(negedge wbclk);
            waited++;
        end while (!wb_ack_o && waited < 16);
        if (!wb_ack_o) begin
            abort_run($sformatf("no wishbone ack for address %h", adr));
        end else begin
            // read data valid while ack is high
            rdata    = wb_dat_o;
            wb_cyc_i = 1'b0;
            wb_stb_i = 1'b0;
            wb_we_i  = 1'b0;
        end
    endtask

    task automatic wb_write(logic [`AGC_ADR_W-1:0] adr, logic [`AGC_DAT_W-1:0] data);
        logic [`AGC_DAT_W-1:0] unused;
        bus_access(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [`AGC_ADR_W-1:0] adr,
                           output logic [`AGC_DAT_W-1:0] data);
        bus_access(1'b0, adr, '0, data);
    endtask

    function automatic logic [`AGC_DAT_W-1:0] ctrl_bit(int pos);
        return 32'd1 << pos;
    endfunction

    function automatic logic [31:0] lcg_next(logic [31:0] st);
        return st * 32'd1664525 + 32'd1013904223;
    endfunction

    // (sample + offset) * scale then floor shift by 12 and clamp to -16..15
    function automatic agc_pkg::trig_sample_t model_lane(agc_pkg::adc_sample_t s,
                                                         agc_pkg::agc_gain_t g);
        longint q;
        longint hi;
        longint lo;
        hi = longint'((1 << (`AGC_OUT_W - 1)) - 1);
        lo = -hi - longint'(1);
        q  = ((longint'(s) + longint'(g.offset)) * longint'(g.scale)) >>> `AGC_SCALE_FRAC;
        if (q > hi) begin
            q = hi;
        end
        if (q < lo) begin
            q = lo;
        end
        return agc_pkg::trig_sample_t'(q);
    endfunction

    function automatic agc_pkg::trig_frame_t model_frame(agc_pkg::adc_frame_t f,
                                                         agc_pkg::agc_gain_t g);
        agc_pkg::trig_frame_t t;
        for (int k = 0; k < `AGC_LANES; k++) begin
            t[k] = model_lane(f[k], g);
        end
        return t;
    endfunction

    // shift narrows the samples toward zero
    task automatic random_frame(input int shift, output agc_pkg::adc_frame_t f);
        for (int k = 0; k < `AGC_LANES; k++) begin
            lcg_state = lcg_next(lcg_state);
            f[k] = $signed(lcg_state[31:20]) >>> shift;
        end
    endtask

    // write shadow then load both fields and apply
    task automatic set_gain(int scale, int offset);
        wb_write(`AGC_REG_SCALE, scale);
        wb_write(`AGC_REG_OFFSET, offset);
        wb_write(`AGC_REG_CTRL, ctrl_bit(`AGC_CTRL_LOAD_SCALE) |
                                ctrl_bit(`AGC_CTRL_LOAD_OFFSET));
        wb_write(`AGC_REG_CTRL, ctrl_bit(`AGC_CTRL_APPLY));
        cur_gain.scale  = agc_pkg::agc_scale_t'(scale);
        cur_gain.offset = agc_pkg::agc_offset_t'(offset);
    endtask

    // new frame every cycle with output checked two falling edges later
    task automatic run_random(int n, int shift);
        agc_pkg::adc_frame_t  f;
        agc_pkg::trig_frame_t expect_q[$];
        for (int i = 0; i < n + 2; i++) begin
            @(negedge wbclk);
            if (i >= 2) begin
                compare_trig(trig_o, expect_q.pop_front(), "trig_o");
            end
            if (i < n) begin
                random_frame(shift, f);
                adc_i = f;
                expect_q.push_back(model_frame(f, cur_gain));
            end
        end
    endtask

    task automatic check_frame(agc_pkg::adc_frame_t f, agc_pkg::trig_frame_t exp);
        @(negedge wbclk);
        adc_i = f;
        repeat (2) @(negedge wbclk);
        compare_trig(trig_o, exp, "trig_o");
    endtask

    task automatic test_reset_state();
        logic [`AGC_DAT_W-1:0] word;
        compare_trig(trig_o, '0, "trig_o");
        wb_read(`AGC_REG_CTRL, word);
        compare_word(word, 32'd0, "ctrl");
        wb_read(`AGC_REG_SCALE, word);
        compare_word(word, 32'd4096, "scale");
        wb_read(`AGC_REG_OFFSET, word);
        compare_word(word, 32'd0, "offset");
    endtask

    task automatic test_register_path();
        agc_pkg::adc_frame_t   f;
        logic [`AGC_DAT_W-1:0] word;
        f = {12'sd19, 12'sd7, 12'sd2, 12'sd0, -12'sd1, -12'sd3, -12'sd9, -12'sd20};
        @(negedge wbclk);
        adc_i = f;
        wb_write(`AGC_REG_SCALE, 32'd2048);
        wb_write(`AGC_REG_OFFSET, -5);
        wb_read(`AGC_REG_SCALE, word);
        compare_word(word, 32'd2048, "scale");
        // offset reads back sign extended
        wb_read(`AGC_REG_OFFSET, word);
        compare_word(word, 32'hffff_fffb, "offset");
        // staged only so datapath still runs the reset gain
        wb_write(`AGC_REG_CTRL, ctrl_bit(`AGC_CTRL_LOAD_SCALE) |
                                ctrl_bit(`AGC_CTRL_LOAD_OFFSET));
        repeat (3) @(negedge wbclk);
        compare_trig(trig_o, model_frame(f, cur_gain), "trig_o");
        wb_write(`AGC_REG_CTRL, ctrl_bit(`AGC_CTRL_APPLY));
        cur_gain.scale  = 13'd2048;
        cur_gain.offset = -14'sd5;
        repeat (3) @(negedge wbclk);
        compare_trig(trig_o, model_frame(f, cur_gain), "trig_o");
    endtask

    task automatic test_gain_path();
        int scales[5]  = '{4096, 2048, 60, 25, 8191};
        int offsets[5] = '{0, -3, 0, -700, 11};
        int shifts[5]  = '{7, 6, 0, 0, 8};
        for (int s = 0; s < 5; s++) begin
            set_gain(scales[s], offsets[s]);
            run_random(40, shifts[s]);
        end
    endtask

    task automatic test_saturation();
        agc_pkg::adc_frame_t  f;
        agc_pkg::trig_frame_t exp;
        set_gain(8191, 0);
        for (int k = 0; k < `AGC_LANES; k++) begin
            f[k]   = (k % 2 == 0) ? 12'sd2047 : -12'sd2047;
            exp[k] = (k % 2 == 0) ? 5'b01111 : 5'b10000;
        end
        check_frame(f, exp);
        // swap signs per lane
        check_frame(~f, ~exp);
    endtask

    task automatic measure_const(int sample, int scale, int offset);
        agc_pkg::adc_frame_t   f;
        logic [`AGC_DAT_W-1:0] word;
        int                    y;
        int                    polls;
        int                    total;
        for (int k = 0; k < `AGC_LANES; k++) begin
            f[k] = agc_pkg::adc_sample_t'(sample);
        end
        @(negedge wbclk);
        adc_i = f;
        set_gain(scale, offset);
        repeat (3) @(negedge wbclk);
        y     = int'(model_lane(f[0], cur_gain));
        total = `AGC_LANES * (1 << `AGC_PERIOD_LOG2);
        wb_write(`AGC_REG_CTRL, ctrl_bit(`AGC_CTRL_START));
        polls = 0;
        word  = '0;
        while (!word[0]) begin
            if (polls >= 64) begin
                abort_run("measurement done never set after start");
            end else begin
                wb_read(`AGC_REG_CTRL, word);
                polls++;
            end
        end
        wb_read(`AGC_REG_SQ, word);
        compare_sq(word[`AGC_SQ_W-1:0], agc_pkg::sq_acc_t'(total * y * y), "sq");
        wb_read(`AGC_REG_GT, word);
        compare_cnt(word[`AGC_CNT_W-1:0], agc_pkg::agc_cnt_t'((y > 0) ? total : 0), "gt");
        wb_read(`AGC_REG_LT, word);
        compare_cnt(word[`AGC_CNT_W-1:0], agc_pkg::agc_cnt_t'((y < 0) ? total : 0), "lt");
        // clear drops done and all results
        wb_write(`AGC_REG_CTRL, ctrl_bit(`AGC_CTRL_CLEAR));
        wb_read(`AGC_REG_CTRL, word);
        compare_word(word, 32'd0, "ctrl");
        wb_read(`AGC_REG_SQ, word);
        compare_sq(word[`AGC_SQ_W-1:0], '0, "sq");
        wb_read(`AGC_REG_GT, word);
        compare_cnt(word[`AGC_CNT_W-1:0], '0, "gt");
        wb_read(`AGC_REG_LT, word);
        compare_cnt(word[`AGC_CNT_W-1:0], '0, "lt");
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        reset_i   = 1'b1;
        wb_cyc_i  = 1'b0;
        wb_stb_i  = 1'b0;
        wb_we_i   = 1'b0;
        wb_adr_i  = '0;
        wb_dat_i  = '0;
        adc_i     = '0;
        lcg_state = 32'hfaf9_4f5c;
        cur_gain.scale  = `AGC_SCALE_RESET;
        cur_gain.offset = '0;
        // two rising edges in reset
        repeat (2) @(negedge wbclk);
        reset_i = 1'b0;

        test_reset_state();
        test_register_path();
        test_gain_path();
        test_saturation();
        // y = 10 and y = -13
        measure_const(40, 1024, 0);
        measure_const(-50, 1024, 0);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+src
src/agc_pkg.sv
src/agc_wb_regs.sv
src/agc_gain_stage.sv
src/agc_quantize_stage.sv
src/agc_measure.sv
src/agc_chain_top.sv
testbench/agc_chain_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the agc chain testbench with verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --assert --top-module agc_chain_tb -f filelist.f \
    -o agc_chain_sim > "$log" 2>&1 \
    || { echo "verilator build failed, see $log"; exit 1; }

./obj_dir/agc_chain_sim >> "$log" 2>&1

# result comes from the log, not the exit status
grep -qF '*** FAILED ***' "$log" && { echo "simulation failed, see $log"; exit 1; }
grep -qF '*** PASSED ***' "$log" || { echo "no result found in $log"; exit 1; }
echo "simulation passed"
